/* verif/gmac_testdata.txt */
// Columns: direction (0 receive, 1 transmit), length, seed offset, status (1 good, 2 bad),
// stall (receive queue or MAC ack held off); direction f ends the list
0 01 00 1 0
0 07 01 2 0
0 08 02 1 0
0 09 03 2 0
0 40 04 1 0
1 01 05 1 0
1 08 06 1 0
1 0d 07 2 0
1 40 08 1 0
0 a0 09 1 1
1 c8 0a 1 1
1 2b 0b 1 0
f 00 00 0 0

/* vlog.f */
+incdir+hdl
hdl/gmac_pkg.sv
hdl/word_stream_if.sv
hdl/word_fifo.sv
hdl/rx_word_packer.sv
hdl/tx_byte_serializer.sv
hdl/gmac_client_top.sv
verif/tb_gmac_client.sv

/* Makefile */
# Verilator build and run for the MAC client datapath testbench
VERILATOR ?= verilator
TOP       ?= tb_gmac_client
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/tb_gmac_client.sv */
/*
 * Testbench for the MAC client datapath
 * Frame cases from a data file, receive and transmit checkers, random MAC ack
 */

`timescale 1ns/10ps

`include "gmac_config.svh"

module tb_gmac_client import gmac_pkg::*; ();

  localparam logic [31:0] SEED = 32'hdd2b5980;
  localparam int          TMO  = 4000;          // Cycles per wait

  logic  clkin;
  logic  rst;
  byte_t rx_data;
  logic  rx_dv, rx_good, rx_bad;
  word_t rxq_bits;
  aux_t  rxq_aux_bits;
  logic  rxq_val, rxq_rdy;
  word_t txq_bits;
  aux_t  txq_aux_bits;
  logic  txq_val, txq_rdy;
  byte_t tx_data;
  logic  tx_valid, tx_ack, rx_overflow;

  logic [31:0] td_mem [0:99];    // Five values per case
  word_t exp_rx_w [$];
  aux_t  exp_rx_a [$];
  byte_t exp_tx_b [$];
  bit    exp_tx_last [$];         // Marks the last byte of a frame
  logic  ack_block;
  logic  need_ack = 1'b1;
  logic  holding = 1'b0;
  int    err_cnt;
  int    mon_err_cnt = 0;
  int    tmo_cnt;
  int    c;

  gmac_client_top u_gmac_client_top (.*);

  initial
  begin
    clkin = 1'b0;
    forever #10 clkin = ~clkin;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Closing side-band byte, end flag plus status plus last index
  function automatic aux_t end_aux(input logic [1:0] status, input int len);
    return 8'h40 | (status[0] ? 8'h20 : 8'h00) | (status[1] ? 8'h10 : 8'h00)
           | 8'((len - 1) % 8);
  endfunction

  function automatic int report_mismatch(input string name, input logic [63:0] exp_v,
                                         input logic [63:0] act_v);
    $display("Error: %s expected %h, got %h", name, exp_v, act_v);
    return 1;
  endfunction

  function automatic int report_failure(input string msg);
    $display("%s", msg);
    return 1;
  endfunction

  // MAC acknowledge --------------------
  initial
  begin : ack_gen
    logic [31:0] ack_rng;
    ack_rng = SEED;
    tx_ack  = 1'b0;
    forever
    begin
      @(posedge clkin);
      #2;
      ack_rng = xorshift32(ack_rng);
      tx_ack  = !ack_block && (ack_rng[2:0] == 3'd0);   // About one cycle in eight
    end
  end

  // Checkers --------------------
  always @(negedge clkin)
  begin
    if (!rst && rxq_val && rxq_rdy)
    begin
      assert (exp_rx_w.size() > 0) else
        mon_err_cnt += report_failure("Receive queue delivered a word that was not expected");
      if (exp_rx_w.size() > 0)
      begin
        assert (rxq_bits == exp_rx_w[0]) else
          mon_err_cnt += report_mismatch("rxq_bits", exp_rx_w[0], rxq_bits);
        assert (rxq_aux_bits == exp_rx_a[0]) else
          mon_err_cnt += report_mismatch("rxq_aux_bits", 64'(exp_rx_a[0]), 64'(rxq_aux_bits));
        void'(exp_rx_w.pop_front());
        void'(exp_rx_a.pop_front());
      end
    end
    if (!rst)
    begin
      if (holding)
      begin
        assert (tx_valid) else
          mon_err_cnt += report_failure("tx_valid dropped while byte 0 waited for tx_ack");
      end
      holding = 1'b0;
      if (tx_valid)
      begin
        assert (exp_tx_b.size() > 0) else
          mon_err_cnt += report_failure("MAC transmit sent a byte that was not expected");
        if (exp_tx_b.size() > 0)
        begin
          assert (tx_data == exp_tx_b[0]) else
            mon_err_cnt += report_mismatch("tx_data", 64'(exp_tx_b[0]), 64'(tx_data));
          if (need_ack && !tx_ack)
            holding = 1'b1;                 // Byte 0 held for the MAC
          else
          begin
            need_ack = exp_tx_last.pop_front();
            void'(exp_tx_b.pop_front());
          end
        end
      end
    end
  end

  // Drivers --------------------
  task automatic wait_for_drain();
    int t;
    t = 0;
    while ((exp_rx_w.size() != 0 || exp_tx_b.size() != 0) && t < TMO)
    begin
      @(posedge clkin);
      t++;
    end
    if (exp_rx_w.size() != 0 || exp_tx_b.size() != 0)
    begin
      $display("Timeout: expected receive words or transmit bytes never arrived");
      tmo_cnt++;
    end
    @(posedge clkin);
    #2;
  endtask

  task automatic push_tx_word(input word_t w, input aux_t a);
    int t;
    txq_bits     = w;
    txq_aux_bits = a;
    txq_val      = 1'b1;
    t            = 0;
    @(negedge clkin);
    while (!txq_rdy && t < TMO)
    begin
      @(negedge clkin);
      t++;
    end
    if (!txq_rdy)
    begin
      $display("Timeout: transmit queue never accepted a word");
      tmo_cnt++;
    end
    @(posedge clkin);
    #2;
    txq_val = 1'b0;
  endtask

  // One receive frame, stall holds the client off to force overflow
  task automatic rx_case(input int len, input logic [31:0] offs, input logic [1:0] status,
                         input logic stall);
    logic [31:0] rng;
    word_t       w;
    int          n;
    int          t;
    rng     = SEED + offs;
    w       = '0;
    rxq_rdy = !stall;
    for (n = 0; n < len; n++)
    begin
      rng = xorshift32(rng);
      w[(n % 8) * 8 +: 8] = rng[7:0];
      if ((n % 8 == 7 || n == len - 1) && (!stall || n / 8 < `GMAC_FIFO_DEPTH))
      begin
        exp_rx_w.push_back(w);
        exp_rx_a.push_back((n == len - 1) ? end_aux(status, len) : 8'h07);
      end
      if (n % 8 == 7)
        w = '0;
      rx_dv   = 1'b1;
      rx_data = rng[7:0];
      @(posedge clkin);
      #2;
    end
    rx_dv   = 1'b0;
    rx_good = status[0];
    rx_bad  = status[1];
    @(posedge clkin);
    #2;
    rx_good = 1'b0;
    rx_bad  = 1'b0;
    if (stall)
    begin
      t = 0;
      while (!rx_overflow && t < TMO)
      begin
        @(negedge clkin);
        t++;
      end
      assert (rx_overflow) else err_cnt += report_mismatch("rx_overflow", 64'h1, 64'(rx_overflow));
      @(posedge clkin);
      #2;
      rxq_rdy = 1'b1;
    end
    wait_for_drain();
  endtask

  // One transmit frame, stall blocks the ack until the queue is full
  task automatic tx_case(input int len, input logic [31:0] offs, input logic [1:0] status,
                         input logic stall);
    logic [31:0] rng;
    word_t       w;
    int          n;
    int          nw;
    rng = SEED + offs;
    w   = '0;
    nw  = 0;
    if (stall)
    begin
      wait_for_drain();
      ack_block = 1'b1;
    end
    for (n = 0; n < len; n++)
    begin
      rng = xorshift32(rng);
      w[(n % 8) * 8 +: 8] = rng[7:0];
      exp_tx_b.push_back(rng[7:0]);
      exp_tx_last.push_back(n == len - 1);
      if (n % 8 == 7 || n == len - 1)
      begin
        push_tx_word(w, (n == len - 1) ? end_aux(status, len) : 8'h07);
        w = '0;
        nw++;
        if (stall && nw == `GMAC_FIFO_DEPTH)
        begin
          @(negedge clkin);
          assert (!txq_rdy) else err_cnt += report_mismatch("txq_rdy", 64'h0, 64'(txq_rdy));
          ack_block = 1'b0;
          @(posedge clkin);
          #2;
        end
      end
    end
  endtask

  initial
  begin
    rst          = 1'b1;
    rx_data      = '0;
    rx_dv        = 1'b0;
    rx_good      = 1'b0;
    rx_bad       = 1'b0;
    rxq_rdy      = 1'b1;
    txq_bits     = '0;
    txq_aux_bits = '0;
    txq_val      = 1'b0;
    ack_block    = 1'b0;
    err_cnt      = 0;
    tmo_cnt      = 0;
    $readmemh("verif/gmac_testdata.txt", td_mem);
    repeat (8) @(posedge clkin);
    #2;
    rst = 1'b0;
    @(negedge clkin);
    assert (!rxq_val) else err_cnt += report_mismatch("rxq_val", 64'h0, 64'(rxq_val));
    assert (!tx_valid) else err_cnt += report_mismatch("tx_valid", 64'h0, 64'(tx_valid));
    assert (!rx_overflow) else err_cnt += report_mismatch("rx_overflow", 64'h0, 64'(rx_overflow));
    assert (txq_rdy) else err_cnt += report_mismatch("txq_rdy", 64'h1, 64'(txq_rdy));
    @(posedge clkin);
    #2;
    for (c = 0; c < 20 && td_mem[5 * c] != 32'hf; c++)
    begin
      if (td_mem[5 * c] == 32'h0)
        rx_case(td_mem[5 * c + 1], td_mem[5 * c + 2], td_mem[5 * c + 3][1:0], td_mem[5 * c + 4][0]);
      else
        tx_case(td_mem[5 * c + 1], td_mem[5 * c + 2], td_mem[5 * c + 3][1:0], td_mem[5 * c + 4][0]);
    end
    wait_for_drain();
    $display("Errors: %0d, timeouts: %0d", err_cnt + mon_err_cnt, tmo_cnt);
    if (err_cnt + mon_err_cnt + tmo_cnt == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* hdl/gmac_client_top.sv */
/*
 * MAC client datapath top
 * Receive packer and queue, transmit queue and serializer
 */

`timescale 1ns/10ps

module gmac_client_top import gmac_pkg::*; (
  input  logic  clkin,
  input  logic  rst,

  // MAC receive
  input  byte_t rx_data,
  input  logic  rx_dv,
  input  logic  rx_good,
  input  logic  rx_bad,

  // Client receive queue
  output word_t rxq_bits,
  output aux_t  rxq_aux_bits,
  output logic  rxq_val,
  input  logic  rxq_rdy,

  // Client transmit queue
  input  word_t txq_bits,
  input  aux_t  txq_aux_bits,
  input  logic  txq_val,
  output logic  txq_rdy,

  // MAC transmit
  output byte_t tx_data,
  output logic  tx_valid,
  input  logic  tx_ack,

  output logic  rx_overflow
);

  word_stream_if rx_wr ();
  word_stream_if rxq_if ();   // Receive queue to client pins
  word_stream_if txq_if ();   // Client pins to transmit queue
  word_stream_if tx_rd ();

  // Receive path --------------------
  rx_word_packer u_rx_pack (.clkin(clkin), .rst(rst), .rx_data(rx_data), .rx_dv(rx_dv),
                            .rx_good(rx_good), .rx_bad(rx_bad), .wr(rx_wr.producer),
                            .rx_overflow(rx_overflow));

  word_fifo u_rxq (.clkin(clkin), .rst(rst), .wr(rx_wr.consumer), .rd(rxq_if.producer));

  assign rxq_bits     = rxq_if.data;
  assign rxq_aux_bits = rxq_if.aux;
  assign rxq_val      = rxq_if.val;
  assign rxq_if.rdy   = rxq_rdy;

  // Transmit path --------------------
  assign txq_if.data = txq_bits;
  assign txq_if.aux  = txq_aux_bits;
  assign txq_if.val  = txq_val;
  assign txq_rdy     = txq_if.rdy;

  word_fifo u_txq (.clkin(clkin), .rst(rst), .wr(txq_if.consumer), .rd(tx_rd.producer));

  tx_byte_serializer u_tx_ser (.clkin(clkin), .rst(rst), .rd(tx_rd.consumer),
                               .tx_data(tx_data), .tx_valid(tx_valid), .tx_ack(tx_ack));

endmodule

/* hdl/tx_byte_serializer.sv */
/*
 * Transmit word serializer
 * Sends queued words to the MAC one byte per cycle, first byte waits for ack
 */

`timescale 1ns/10ps

module tx_byte_serializer import gmac_pkg::*; (
  input logic             clkin,
  input logic             rst,
  word_stream_if.consumer rd,
  output byte_t           tx_data,
  output logic            tx_valid,
  input logic             tx_ack
);

  localparam int IDX_W = $bits(byte_idx_t);

  tx_state_t state;
  tx_state_t state_nx;
  byte_idx_t idx;
  byte_idx_t idx_nx;
  logic      last_byte;
  logic      frame_end;
  logic      advance;

  assign last_byte = (idx == rd.aux[IDX_W-1:0]);
  assign frame_end = rd.aux[AUX_END_BIT];

  // Outside SEND the byte only moves on the MAC acknowledge
  assign advance = rd.val && ((state == SEND) || tx_ack);

  assign tx_valid = rd.val;                          // Drops on underrun
  assign tx_data  = rd.data[idx*BYTE_W +: BYTE_W];
  assign rd.rdy   = advance && last_byte;            // Pop after the last byte

  // Next state --------------------
  always_comb
  begin
    state_nx = state;
    idx_nx   = idx;
    if (!rd.val)
    begin
      state_nx = IDLE;
      idx_nx   = '0;
    end
    else if (advance)
    begin
      if (last_byte)
      begin
        idx_nx   = '0;
        state_nx = frame_end ? IDLE : SEND;    // Next frame needs a fresh ack
      end
      else
      begin
        idx_nx   = idx + 1'b1;
        state_nx = SEND;
      end
    end
    else if (state == IDLE)
      state_nx = WAIT_ACK;                     // Byte 0 presented, hold it
  end

  always_ff @(posedge clkin or posedge rst)
  begin
    if (rst)
    begin
      state <= IDLE;
      idx   <= '0;
    end
    else
    begin
      state <= state_nx;
      idx   <= idx_nx;
    end
  end

endmodule

/* hdl/rx_word_packer.sv */
/*
 * Receive byte packer
 * Collects MAC bytes into words, tags frame end and status, flags overflow
 */

`timescale 1ns/10ps

module rx_word_packer import gmac_pkg::*; (
  input logic             clkin,
  input logic             rst,
  input byte_t            rx_data,
  input logic             rx_dv,
  input logic             rx_good,
  input logic             rx_bad,
  word_stream_if.producer wr,
  output logic            rx_overflow
);

  localparam byte_idx_t IDX_LAST = '1;
  localparam aux_t      FULL_AUX = aux_t'(IDX_LAST);    // Mid-frame word, all bytes valid

  rx_state_t state;
  byte_idx_t idx;
  byte_idx_t last_idx;
  word_t     word_buf;
  word_t     out_data;
  aux_t      out_aux;
  aux_t      end_aux;
  logic      out_val;
  logic      frame_done;

  assign frame_done = rx_good | rx_bad;
  assign last_idx   = idx - 1'b1;    // idx is 0 in HOLD, so a full word gives 7

  // Side-band byte for the closing word
  always_comb
  begin
    end_aux                           = '0;
    end_aux[AUX_END_BIT]              = 1'b1;
    end_aux[AUX_GOOD_BIT]             = rx_good;
    end_aux[AUX_BAD_BIT]              = rx_bad;
    end_aux[$bits(byte_idx_t)-1:0]    = last_idx;
  end

  // Control --------------------
  always_ff @(posedge clkin or posedge rst)
  begin
    if (rst)
    begin
      state       <= COLLECT;
      idx         <= '0;
      out_val     <= 1'b0;
      rx_overflow <= 1'b0;
    end
    else
    begin
      out_val <= 1'b0;                // One write pulse per event
      if (out_val && !wr.rdy)
        rx_overflow <= 1'b1;          // Word lost, sticky until reset
      if (frame_done)
      begin
        state   <= COLLECT;
        idx     <= '0;
        out_val <= 1'b1;
      end
      else if (rx_dv)
      begin
        idx <= idx + 1'b1;
        if (state == HOLD)
        begin
          out_val <= 1'b1;            // Held word goes out, new byte starts next one
          state   <= COLLECT;
        end
        else if (idx == IDX_LAST)
          state <= HOLD;
      end
    end
  end

  // Payload --------------------
  always_ff @(posedge clkin)
  begin
    if (frame_done)
    begin
      out_data <= word_buf;
      out_aux  <= end_aux;
    end
    else if (rx_dv)
    begin
      if (state == HOLD)
      begin
        out_data <= word_buf;
        out_aux  <= FULL_AUX;
      end
      if (idx == '0)
        word_buf <= word_t'(rx_data);   // Fresh word, upper bytes zero
      else
        word_buf[idx*BYTE_W +: BYTE_W] <= rx_data;
    end
  end

  assign wr.data = out_data;
  assign wr.aux  = out_aux;
  assign wr.val  = out_val;

endmodule

/* hdl/word_fifo.sv */
/*
 * Synchronous first-word-fall-through queue
 * Holds word plus side-band entries, full/empty shown through rdy/val
 */

`timescale 1ns/10ps

`include "gmac_config.svh"

module word_fifo import gmac_pkg::*; #(
  parameter int DEPTH = `GMAC_FIFO_DEPTH
) (
  input logic             clkin,
  input logic             rst,
  word_stream_if.consumer wr,
  word_stream_if.producer rd
);

  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

  word_t data_mem [DEPTH];
  aux_t  aux_mem  [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          push;
  logic          pop;

  // Handshake --------------------
  assign wr.rdy = (count != FULL_CNT);    // val ignored while full
  assign rd.val = (count != '0);
  assign push   = wr.val & wr.rdy;
  assign pop    = rd.val & rd.rdy;

  // Head entry falls through to the read side
  assign rd.data = data_mem[rd_ptr];
  assign rd.aux  = aux_mem[rd_ptr];

  always_ff @(posedge clkin or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;      // Wraps at DEPTH
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;      // Both or neither
      endcase
    end
  end

  // Storage --------------------
  always_ff @(posedge clkin)
  begin
    if (push)
    begin
      data_mem[wr_ptr] <= wr.data;
      aux_mem[wr_ptr]  <= wr.aux;
    end
  end

endmodule

/* hdl/word_stream_if.sv */
/*
 * Word stream with side-band byte and valid/ready handshake
 */

`timescale 1ns/10ps

interface word_stream_if import gmac_pkg::*; ();

  word_t data;
  aux_t  aux;
  logic  val;
  logic  rdy;     // Entry moves when val and rdy are both high

  modport producer (
    output data, aux, val,
    input  rdy
  );

  modport consumer (
    input  data, aux, val,
    output rdy
  );

endinterface

/* hdl/gmac_pkg.sv */
/*
 * Shared types for the MAC client datapath
 * Word, side-band, byte and index types, side-band bit positions, FSM states
 */

`include "gmac_config.svh"

package gmac_pkg;

  typedef logic [`GMAC_WORD_W-1:0]                  word_t;      // Byte 0 in the low bits
  typedef logic [`GMAC_AUX_W-1:0]                   aux_t;
  typedef logic [7:0]                               byte_t;
  typedef logic [$clog2(`GMAC_BYTES_PER_WORD)-1:0]  byte_idx_t;

  localparam int BYTE_W = $bits(byte_t);

  // Side-band byte, low bits hold the last-byte index
  localparam int AUX_END_BIT  = 6;
  localparam int AUX_GOOD_BIT = 5;
  localparam int AUX_BAD_BIT  = 4;

  typedef enum logic {COLLECT, HOLD} rx_state_t;

  typedef enum logic [1:0] {IDLE, WAIT_ACK, SEND} tx_state_t;

endpackage

/* hdl/gmac_config.svh */
/*
 * Build-time sizes for the MAC client datapath
 * Word width, bytes per word, side-band width, queue depth
 */

`ifndef GMAC_CONFIG_SVH
`define GMAC_CONFIG_SVH

// Client word layout
`define GMAC_WORD_W          64
`define GMAC_BYTES_PER_WORD  8
`define GMAC_AUX_W           8

// Entries per queue, power of two
`define GMAC_FIFO_DEPTH      16

`endif
